//--- Makefile
BIN  := obj_dir/Vtb_lcd_ctrl
SRCS := flist.f $(wildcard verilog/*.sv) $(wildcard testbench/*.sv testbench/*.svh)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

$(BIN): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lcd_ctrl -f flist.f

clean:
	rm -rf obj_dir

//--- flist.f
+incdir+testbench
verilog/ahb_pkg.sv
verilog/lcd_pkg.sv
verilog/lcd_pin_regs.sv
verilog/lcd_init_seq.sv
verilog/lcd_bus_select.sv
verilog/lcd_ctrl_top.sv
testbench/tb_lcd_ctrl.sv

//--- testbench/tb_lcd_bus.svh
`ifndef TB_LCD_BUS_SVH
`define TB_LCD_BUS_SVH

// --------------------
// reference model
// --------------------
lcd_pkg::lcd_pins_t model_sw;
logic               model_mode;
logic [16:0]        cmd_exp [0:15];
logic [3:0]         n_cmds;
logic               rd_chk;
logic               rd_exp;

function automatic void model_reset();
    model_sw   = '0;
    model_mode = 1'b0;
    rd_chk     = 1'b0;
    rd_exp     = 1'b0;
endfunction

// commands of the init program in order, {rs, data}
function automatic void build_cmd_list();
    lcd_pkg::lcd_init_word_t w;
    n_cmds = '0;
    for (int i = 0; i < lcd_pkg::INIT_LEN; i++) begin
        w = lcd_pkg::INIT_ROM[i];
        if (!w.cmd.is_delay) begin
            cmd_exp[n_cmds] = {w.cmd.rs, w.cmd.data};
            n_cmds = n_cmds + 4'd1;
        end
    end
endfunction

// called 2 ns after a rising edge, returns 2 ns after the data phase ends
task automatic ahb_write(input logic [5:0] ofs, input logic val);
    HSEL   = 1'b1;
    HTRANS = ahb_pkg::HTRANS_NONSEQ;
    HWRITE = 1'b1;
    HADDR  = {24'h0, ofs, 2'b00};
    @(posedge HCLK);
    #2;
    HSEL   = 1'b0;
    HTRANS = ahb_pkg::HTRANS_IDLE;
    HWRITE = 1'b0;
    HWDATA = {31'h0, val};
    @(posedge HCLK);
    #2;
    case (ofs)
        lcd_pkg::REG_CS:   model_sw.cs  = val;
        lcd_pkg::REG_RS:   model_sw.rs  = val;
        lcd_pkg::REG_WR:   model_sw.wr  = val;
        lcd_pkg::REG_RD:   model_sw.rd  = val;
        lcd_pkg::REG_RST:  model_sw.rst = val;
        lcd_pkg::REG_BL:   model_sw.bl  = val;
        lcd_pkg::REG_MODE: model_mode   = val;
        default: begin
            if (ofs >= lcd_pkg::REG_DATA0 && ofs <= lcd_pkg::REG_DATA0 + 6'd15) begin
                model_sw.data[4'(ofs - lcd_pkg::REG_DATA0)] = val;
            end
        end
    endcase
endtask

// chk arms the read data check for the data phase
task automatic ahb_read(input logic [5:0] ofs, input logic chk, input logic exp,
                        output logic [31:0] data);
    HSEL   = 1'b1;
    HTRANS = ahb_pkg::HTRANS_NONSEQ;
    HWRITE = 1'b0;
    HADDR  = {24'h0, ofs, 2'b00};
    @(posedge HCLK);
    #2;
    HSEL   = 1'b0;
    HTRANS = ahb_pkg::HTRANS_IDLE;
    rd_chk = chk;
    rd_exp = exp;
    #8 data = HRDATA;
    @(posedge HCLK);
    #2 rd_chk = 1'b0;
endtask

`endif

//--- testbench/tb_lcd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_ctrl;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int REG_TEST_CYCLES = 400;
    localparam int MARGIN_CYCLES   = 200;

    logic               HCLK;
    logic               HRESETn;
    logic               HSEL;
    logic [31:0]        HADDR;
    logic [1:0]         HTRANS;
    logic               HWRITE;
    logic [31:0]        HWDATA;
    logic               HREADY;
    wire                HREADYOUT;
    wire  [31:0]        HRDATA;
    wire                HRESP;
    wire                lcd_cs;
    wire                lcd_rs;
    wire                lcd_wr;
    wire                lcd_rd;
    wire                lcd_rst;
    wire  [15:0]        lcd_data;
    wire                lcd_bl;

    lcd_pkg::lcd_pins_t panel;
    logic               sw_follow;
    logic               done_chk;
    logic               wr_q;
    logic [3:0]         strobe_cnt;
    int                 bus_errs;
    int                 pin_errs;
    int                 seq_errs;
    integer             seed;

    `include "tb_lcd_bus.svh"

    lcd_ctrl_top dut0 (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .HREADYOUT (HREADYOUT),
        .HRDATA    (HRDATA),
        .HRESP     (HRESP),
        .lcd_cs    (lcd_cs),
        .lcd_rs    (lcd_rs),
        .lcd_wr    (lcd_wr),
        .lcd_rd    (lcd_rd),
        .lcd_rst   (lcd_rst),
        .lcd_data  (lcd_data),
        .lcd_bl    (lcd_bl)
    );

    assign panel = {lcd_cs, lcd_rs, lcd_wr, lcd_rd, lcd_rst, lcd_bl, lcd_data};

    initial begin
        HCLK = 1'b0;
        forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
    end

    // one command costs setup, strobe and hold, a delay its count
    function automatic int init_cycles();
        int total;
        total = 0;
        for (int i = 0; i < lcd_pkg::INIT_LEN; i++) begin
            if (lcd_pkg::INIT_ROM[i].dly.is_delay) begin
                total = total + int'(lcd_pkg::INIT_ROM[i].dly.cycles);
            end else begin
                total = total + 2 + lcd_pkg::WR_LOW_CYCLES;
            end
        end
        return total;
    endfunction

    // rising write strobes seen on the panel while the sequencer owns it
    always @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            wr_q       <= 1'b1;
            strobe_cnt <= '0;
        end else begin
            wr_q <= lcd_wr;
            if (model_mode && lcd_wr && !wr_q && !lcd_cs) begin
                strobe_cnt <= strobe_cnt + 4'd1;
            end
        end
    end

    // --------------------
    // checks
    // --------------------
    a_bus_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
        HREADYOUT && (HRESP == 1'b0))
    else begin
        bus_errs++;
        $display("mismatch at %0t: response not OKAY with HREADYOUT high", $time);
    end

    a_read_data: assert property (@(posedge HCLK) disable iff (!HRESETn)
        rd_chk |-> (HRDATA == {31'b0, rd_exp}))
    else begin
        bus_errs++;
        $display("mismatch at %0t: HRDATA %h, expected bit %b", $time, HRDATA, rd_exp);
    end

    a_sw_pins: assert property (@(posedge HCLK) disable iff (!HRESETn)
        sw_follow |-> (panel == $past(model_sw)))
    else begin
        pin_errs++;
        $display("mismatch at %0t: panel pins %h differ from written registers", $time, panel);
    end

    a_idle_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (model_mode != $past(model_mode)) |=> (panel == lcd_pkg::LCD_PIN_IDLE))
    else begin
        pin_errs++;
        $display("mismatch at %0t: no idle cycle after mode change", $time);
    end

    a_new_owner: assert property (@(posedge HCLK) disable iff (!HRESETn)
        ((model_mode == $past(model_mode)) && (model_mode != $past(model_mode, 2))) |=>
        (panel == (model_mode ? lcd_pkg::LCD_PIN_IDLE : model_sw)))
    else begin
        pin_errs++;
        $display("mismatch at %0t: idle cycle longer than one after mode change", $time);
    end

    a_strobe_cmd: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (model_mode && lcd_wr && !wr_q && !lcd_cs) |->
        ((strobe_cnt < n_cmds) && ({lcd_rs, lcd_data} == cmd_exp[strobe_cnt])))
    else begin
        seq_errs++;
        $display("mismatch at %0t: strobe %0d carries rs %b data %h",
                 $time, strobe_cnt, lcd_rs, lcd_data);
    end

    a_strobe_total: assert property (@(posedge HCLK) disable iff (!HRESETn)
        done_chk |-> (strobe_cnt == n_cmds))
    else begin
        seq_errs++;
        $display("mismatch at %0t: %0d strobes, expected %0d", $time, strobe_cnt, n_cmds);
    end

    // --------------------
    // watchdog
    // --------------------
    initial begin
        int limit;
        limit = RESET_CYCLES + REG_TEST_CYCLES + init_cycles() + MARGIN_CYCLES;
        repeat (limit) @(posedge HCLK);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin
        logic [31:0] d;
        logic [31:0] rnd;
        int          polls;
        HRESETn    = 1'b0;
        HSEL       = 1'b0;
        HADDR      = '0;
        HTRANS     = ahb_pkg::HTRANS_IDLE;
        HWRITE     = 1'b0;
        HWDATA     = '0;
        HREADY     = 1'b1;
        sw_follow  = 1'b1;
        done_chk   = 1'b0;
        bus_errs   = 0;
        pin_errs   = 0;
        seq_errs   = 0;
        seed       = 32'h97fd61ac;
        model_reset();
        build_cmd_list();
        repeat (RESET_CYCLES) @(posedge HCLK);
        #2 HRESETn = 1'b1;
        @(posedge HCLK);
        #2;

        // every mapped register reads zero out of reset
        for (int i = 0; i <= int'(lcd_pkg::REG_STATUS); i++) begin
            ahb_read(6'(i), 1'b1, 1'b0, d);
        end

        // random bit into each pin and data register, then read back
        for (int i = 0; i < int'(lcd_pkg::REG_MODE); i++) begin
            rnd = $random(seed);
            ahb_write(6'(i), rnd[0]);
            ahb_read(6'(i), 1'b1, rnd[0], d);
        end

        for (int i = int'(lcd_pkg::REG_STATUS) + 1; i < 64; i++) begin
            ahb_read(6'(i), 1'b1, 1'b0, d);
        end

        // keep cs low so the idle cycle differs from the software pins
        ahb_write(lcd_pkg::REG_CS, 1'b0);
        repeat (3) @(posedge HCLK);
        #2 sw_follow = 1'b0;
        ahb_write(lcd_pkg::REG_MODE, 1'b1);
        repeat (4) @(posedge HCLK);
        #2;
        ahb_read(lcd_pkg::REG_MODE, 1'b1, 1'b1, d);

        ahb_write(lcd_pkg::REG_INIT, 1'b1);
        ahb_read(lcd_pkg::REG_STATUS, 1'b1, 1'b1, d);
        // restart request while running
        ahb_write(lcd_pkg::REG_INIT, 1'b1);
        ahb_read(lcd_pkg::REG_STATUS, 1'b1, 1'b1, d);

        polls = 0;
        d     = 32'h1;
        while (d[0] && polls < init_cycles() / 2 + 8) begin
            ahb_read(lcd_pkg::REG_STATUS, 1'b0, 1'b0, d);
            polls++;
        end
        if (d[0]) begin
            seq_errs++;
            $display("sequencer still busy after %0d status polls", polls);
        end
        ahb_read(lcd_pkg::REG_STATUS, 1'b1, 1'b0, d);
        repeat (4) @(posedge HCLK);
        #2 done_chk = 1'b1;
        @(posedge HCLK);
        #2 done_chk = 1'b0;

        // hand the panel back to software
        ahb_write(lcd_pkg::REG_MODE, 1'b0);
        repeat (4) @(posedge HCLK);
        #2 sw_follow = 1'b1;
        repeat (4) @(posedge HCLK);

        $display("errors: bus %0d, pins %0d, sequencer %0d", bus_errs, pin_errs, seq_errs);
        if (bus_errs + pin_errs + seq_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

    // --------------------
    // bus widths
    // --------------------
    localparam int AHB_ADDR_W = 32;
    localparam int AHB_DATA_W = 32;

    // word offset bits kept from HADDR[7:2]
    localparam int AHB_OFS_W = 6;

    // --------------------
    // transfer codes
    // --------------------
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // slave response, this slave only ever answers OKAY
    localparam logic HRESP_OKAY = 1'b0;

    // address phase as sampled at the rising edge, used in the data phase
    typedef struct packed {
        logic                 sel;
        logic [1:0]           trans;
        logic                 write;
        logic [AHB_OFS_W-1:0] addr;
    } ahb_addr_t;

endpackage

`default_nettype wire

//--- verilog/lcd_bus_select.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_select (
    input  wire                      HCLK,
    input  wire                      HRESETn,
    input  wire lcd_pkg::lcd_pins_t  sw_pins,
    input  wire lcd_pkg::lcd_pins_t  hw_pins,
    input  wire                      mode,
    output logic                     lcd_cs,
    output logic                     lcd_rs,
    output logic                     lcd_wr,
    output logic                     lcd_rd,
    output logic                     lcd_rst,
    output logic [15:0]              lcd_data,
    output logic                     lcd_bl
);

    logic               mode_q;
    lcd_pkg::lcd_pins_t pins_q;

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            mode_q <= 1'b0;
            pins_q <= '0;
        end else begin
            mode_q <= mode;
            if (mode != mode_q) begin
                // one released cycle between owners
                pins_q <= lcd_pkg::LCD_PIN_IDLE;
            end else begin
                pins_q <= mode ? hw_pins : sw_pins;
            end
        end
    end

    assign lcd_cs   = pins_q.cs;
    assign lcd_rs   = pins_q.rs;
    assign lcd_wr   = pins_q.wr;
    assign lcd_rd   = pins_q.rd;
    assign lcd_rst  = pins_q.rst;
    assign lcd_data = pins_q.data;
    assign lcd_bl   = pins_q.bl;

    a_idle_on_switch: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        $changed(mode) |=> (pins_q == lcd_pkg::LCD_PIN_IDLE)
    );

endmodule

`default_nettype wire

//--- verilog/lcd_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_top (
    input  wire                            HCLK,
    input  wire                            HRESETn,
    input  wire                            HSEL,
    input  wire [ahb_pkg::AHB_ADDR_W-1:0]  HADDR,
    input  wire [1:0]                      HTRANS,
    input  wire                            HWRITE,
    input  wire [ahb_pkg::AHB_DATA_W-1:0]  HWDATA,
    input  wire                            HREADY,
    output wire                            HREADYOUT,
    output wire [ahb_pkg::AHB_DATA_W-1:0]  HRDATA,
    output wire                            HRESP,
    output wire                            lcd_cs,
    output wire                            lcd_rs,
    output wire                            lcd_wr,
    output wire                            lcd_rd,
    output wire                            lcd_rst,
    output wire [15:0]                     lcd_data,
    output wire                            lcd_bl
);

    lcd_pkg::lcd_pins_t sw_pins;
    lcd_pkg::lcd_pins_t hw_pins;
    wire                mode;
    wire                init_start;
    wire                busy;

    // software register path
    lcd_pin_regs u_regs (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HSEL       (HSEL),
        .HADDR      (HADDR),
        .HTRANS     (HTRANS),
        .HWRITE     (HWRITE),
        .HWDATA     (HWDATA),
        .HREADY     (HREADY),
        .busy       (busy),
        .HREADYOUT  (HREADYOUT),
        .HRDATA     (HRDATA),
        .HRESP      (HRESP),
        .sw_pins    (sw_pins),
        .mode       (mode),
        .init_start (init_start)
    );

    // hardware init path
    lcd_init_seq u_seq (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .init_start (init_start),
        .hw_pins    (hw_pins),
        .busy       (busy)
    );

    lcd_bus_select u_sel (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .sw_pins  (sw_pins),
        .hw_pins  (hw_pins),
        .mode     (mode),
        .lcd_cs   (lcd_cs),
        .lcd_rs   (lcd_rs),
        .lcd_wr   (lcd_wr),
        .lcd_rd   (lcd_rd),
        .lcd_rst  (lcd_rst),
        .lcd_data (lcd_data),
        .lcd_bl   (lcd_bl)
    );

endmodule

`default_nettype wire

//--- verilog/lcd_init_seq.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_init_seq (
    input  wire                 HCLK,
    input  wire                 HRESETn,
    input  wire                 init_start,
    output lcd_pkg::lcd_pins_t  hw_pins,
    output logic                busy
);

    localparam int IDX_W = $clog2(lcd_pkg::INIT_LEN);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(lcd_pkg::INIT_LEN - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SETUP,
        S_STROBE,
        S_HOLD,
        S_DELAY
    } seq_state_t;

    seq_state_t             state;
    logic [IDX_W-1:0]       idx;
    logic [IDX_W-1:0]       idx_nxt;
    logic [16:0]            cnt;
    lcd_pkg::lcd_init_word_t cur_w;
    lcd_pkg::lcd_init_word_t nxt_w;

    assign idx_nxt = idx + 1'b1;
    assign cur_w   = lcd_pkg::INIT_ROM[idx];
    assign nxt_w   = lcd_pkg::INIT_ROM[idx_nxt];

    assign busy = (state != S_IDLE);

    // --------------------
    // sequencer FSM
    // --------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state <= S_IDLE;
            idx   <= '0;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    // start ignored while running since only idle looks at it
                    if (init_start) begin
                        idx   <= '0;
                        state <= lcd_pkg::INIT_ROM[0].cmd.is_delay ? S_DELAY : S_SETUP;
                        cnt   <= lcd_pkg::INIT_ROM[0].dly.cycles;
                    end
                end
                S_SETUP: begin
                    state <= S_STROBE;
                    cnt   <= 17'(lcd_pkg::WR_LOW_CYCLES);
                end
                S_STROBE: begin
                    if (cnt <= 17'd1) begin
                        state <= S_HOLD;
                    end else begin
                        cnt <= cnt - 17'd1;
                    end
                end
                S_HOLD, S_DELAY: begin
                    if (state == S_DELAY && cnt > 17'd1) begin
                        cnt <= cnt - 17'd1;
                    end else if (idx == LAST_IDX) begin
                        state <= S_IDLE;
                    end else begin
                        // move straight into the next entry, no gap cycle
                        idx   <= idx_nxt;
                        state <= nxt_w.cmd.is_delay ? S_DELAY : S_SETUP;
                        cnt   <= nxt_w.dly.cycles;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // pin drive
    // --------------------
    always_comb begin
        hw_pins = lcd_pkg::LCD_PIN_IDLE;
        case (state)
            S_SETUP, S_STROBE, S_HOLD: begin
                hw_pins.cs   = 1'b0;
                hw_pins.rs   = cur_w.cmd.rs;
                hw_pins.data = cur_w.cmd.data;
                hw_pins.wr   = (state != S_STROBE);
                hw_pins.rst  = 1'b1;
                hw_pins.bl   = 1'b0;
            end
            S_DELAY: begin
                // keep the panel out of reset between commands
                hw_pins.rst = 1'b1;
            end
            default: begin
                hw_pins = lcd_pkg::LCD_PIN_IDLE;
            end
        endcase
    end

    // a write strobe needs cs already low in the cycle before it
    a_wr_inside_cs: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !hw_pins.wr |-> (!hw_pins.cs && !$past(hw_pins.cs))
    );

endmodule

`default_nettype wire

//--- verilog/lcd_pin_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_pin_regs (
    input  wire                                   HCLK,
    input  wire                                   HRESETn,
    input  wire                                   HSEL,
    input  wire        [ahb_pkg::AHB_ADDR_W-1:0]  HADDR,
    input  wire        [1:0]                      HTRANS,
    input  wire                                   HWRITE,
    input  wire        [ahb_pkg::AHB_DATA_W-1:0]  HWDATA,
    input  wire                                   HREADY,
    input  wire                                   busy,
    output logic                                  HREADYOUT,
    output logic       [ahb_pkg::AHB_DATA_W-1:0]  HRDATA,
    output logic                                  HRESP,
    output lcd_pkg::lcd_pins_t                    sw_pins,
    output logic                                  mode,
    output logic                                  init_start
);

    ahb_pkg::ahb_addr_t aphase;
    logic               dphase_act;
    logic               wr_en;
    logic               rd_en;
    logic               is_data;
    logic [3:0]         data_idx;
    logic               rd_bit;

    // no wait states and no errors
    assign HREADYOUT = 1'b1;
    assign HRESP     = ahb_pkg::HRESP_OKAY;

    // --------------------
    // address phase
    // --------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            aphase <= '0;
        end else if (HREADY) begin
            aphase <= '{sel:   HSEL,
                        trans: HTRANS,
                        write: HWRITE,
                        addr:  HADDR[ahb_pkg::AHB_OFS_W+1:2]};
        end
    end

    assign dphase_act = aphase.sel &&
                        (aphase.trans == ahb_pkg::HTRANS_NONSEQ ||
                         aphase.trans == ahb_pkg::HTRANS_SEQ);
    assign wr_en = dphase_act && aphase.write && HREADY;
    assign rd_en = dphase_act && !aphase.write;

    // data bit offsets form one contiguous window
    assign is_data  = (aphase.addr >= lcd_pkg::REG_DATA0) &&
                      (aphase.addr <  lcd_pkg::REG_DATA0 + 6'd16);
    assign data_idx = 4'(aphase.addr - lcd_pkg::REG_DATA0);

    // --------------------
    // data phase writes
    // --------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            sw_pins    <= '0;
            mode       <= 1'b0;
            init_start <= 1'b0;
        end else begin
            // single cycle kick for the sequencer
            init_start <= wr_en && (aphase.addr == lcd_pkg::REG_INIT) && HWDATA[0];
            if (wr_en) begin
                case (aphase.addr)
                    lcd_pkg::REG_CS:   sw_pins.cs  <= HWDATA[0];
                    lcd_pkg::REG_RS:   sw_pins.rs  <= HWDATA[0];
                    lcd_pkg::REG_WR:   sw_pins.wr  <= HWDATA[0];
                    lcd_pkg::REG_RD:   sw_pins.rd  <= HWDATA[0];
                    lcd_pkg::REG_RST:  sw_pins.rst <= HWDATA[0];
                    lcd_pkg::REG_BL:   sw_pins.bl  <= HWDATA[0];
                    lcd_pkg::REG_MODE: mode        <= HWDATA[0];
                    default: begin
                        if (is_data) begin
                            sw_pins.data[data_idx] <= HWDATA[0];
                        end
                    end
                endcase
            end
        end
    end

    // --------------------
    // read back
    // --------------------
    always_comb begin
        rd_bit = 1'b0;
        case (aphase.addr)
            lcd_pkg::REG_CS:     rd_bit = sw_pins.cs;
            lcd_pkg::REG_RS:     rd_bit = sw_pins.rs;
            lcd_pkg::REG_WR:     rd_bit = sw_pins.wr;
            lcd_pkg::REG_RD:     rd_bit = sw_pins.rd;
            lcd_pkg::REG_RST:    rd_bit = sw_pins.rst;
            lcd_pkg::REG_BL:     rd_bit = sw_pins.bl;
            lcd_pkg::REG_MODE:   rd_bit = mode;
            lcd_pkg::REG_STATUS: rd_bit = busy;
            default: begin
                // REG_INIT and unmapped offsets fall through as zero
                if (is_data) begin
                    rd_bit = sw_pins.data[data_idx];
                end
            end
        endcase
    end

    assign HRDATA = {{(ahb_pkg::AHB_DATA_W-1){1'b0}}, rd_bit & rd_en};

    // masters on this bus never insert BUSY cycles
    a_no_busy_trans: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (HSEL && HREADY) |-> (HTRANS != ahb_pkg::HTRANS_BUSY)
    );

endmodule

`default_nettype wire

//--- verilog/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // --------------------
    // panel pins
    // --------------------
    typedef struct packed {
        logic        cs;
        logic        rs;
        logic        wr;
        logic        rd;
        logic        rst;
        logic        bl;
        logic [15:0] data;
    } lcd_pins_t;

    // bus released: chip select, write and read strobes inactive
    localparam lcd_pins_t LCD_PIN_IDLE = '{cs: 1'b1, rs: 1'b0, wr: 1'b1, rd: 1'b1,
                                           rst: 1'b0, bl: 1'b0, data: 16'h0000};

    // --------------------
    // register map, word offsets
    // --------------------
    localparam logic [ahb_pkg::AHB_OFS_W-1:0] REG_CS     = 6'h00;
    localparam logic [ahb_pkg::AHB_OFS_W-1:0] REG_RS     = 6'h01;
    localparam logic [ahb_pkg::AHB_OFS_W-1:0] REG_WR     = 6'h02;
    localparam logic [ahb_pkg::AHB_OFS_W-1:0] REG_RD     = 6'h03;
    localparam logic [ahb_pkg::AHB_OFS_W-1:0] REG_RST    = 6'h04;
    localparam logic [ahb_pkg::AHB_OFS_W-1:0] REG_BL     = 6'h05;
    // data bit n lives at REG_DATA0 + n, up to 0x15
    localparam logic [ahb_pkg::AHB_OFS_W-1:0] REG_DATA0  = 6'h06;
    localparam logic [ahb_pkg::AHB_OFS_W-1:0] REG_MODE   = 6'h16;
    localparam logic [ahb_pkg::AHB_OFS_W-1:0] REG_INIT   = 6'h17;
    localparam logic [ahb_pkg::AHB_OFS_W-1:0] REG_STATUS = 6'h18;

    // --------------------
    // init program
    // --------------------
    typedef struct packed {
        logic        is_delay;
        logic        rs;
        logic [15:0] data;
    } lcd_init_cmd_t;

    typedef struct packed {
        logic        is_delay;
        logic [16:0] cycles;
    } lcd_init_dly_t;

    // same 18 bits, the top bit picks the view
    typedef union packed {
        lcd_init_cmd_t cmd;
        lcd_init_dly_t dly;
    } lcd_init_word_t;

    localparam int INIT_LEN = 8;

    localparam lcd_init_word_t INIT_ROM [INIT_LEN] = '{
        {1'b0, 1'b0, 16'h0001},    // software reset
        {1'b1, 17'd40},
        {1'b0, 1'b0, 16'h0011},    // sleep out
        {1'b1, 17'd100},
        {1'b0, 1'b0, 16'h003A},    // pixel format
        {1'b0, 1'b1, 16'h0055},    // 16 bpp
        {1'b1, 17'd20},
        {1'b0, 1'b0, 16'h0029}     // display on
    };

    // cycles with wr held low per command
    localparam int WR_LOW_CYCLES = 2;

endpackage

`default_nettype wire
